/* hdl/cache.sv */
`timescale 1ns/1ps

module cache #(
    parameter int SETS = 8
) (
    input  logic                      clk,
    input  logic                      rst,
    input  mem_types_pkg::word_t      mem_addr_i,
    input  logic                      mem_read_i,
    input  logic                      mem_write_i,
    input  mem_types_pkg::line_mask_t mem_mask_i,
    input  mem_types_pkg::line_t      mem_wdata_i,
    output mem_types_pkg::line_t      mem_rdata_o,
    output logic                      mem_resp_o,
    output mem_types_pkg::word_t      pmem_addr_o,
    output logic                      pmem_read_o,
    output logic                      pmem_write_o,
    output mem_types_pkg::line_t      pmem_wdata_o,
    input  mem_types_pkg::line_t      pmem_rdata_i,
    input  logic                      pmem_resp_i,
    output logic                      hit_o,
    output logic                      miss_o
);
    import mem_types_pkg::*;

    localparam int IDX_W = $clog2(SETS);
    localparam int TAG_W = 32 - OFFSET_BITS - IDX_W;

    typedef enum logic [1:0] {
        S_IDLE,
        S_LOOKUP,
        S_WBACK,
        S_FILL
    } state_e;

    state_e state_q;
    state_e state_d;

    line_t            data_arr [SETS];
    logic [TAG_W-1:0] tag_arr  [SETS];
    logic [SETS-1:0]  valid_q;
    logic [SETS-1:0]  dirty_q;
    logic             filled_q;     // second lookup after a fill

    mem_addr_u        req_addr;
    mem_addr_u        fill_addr;
    mem_addr_u        wb_addr;
    logic [IDX_W-1:0] idx;
    logic [TAG_W-1:0] tag;
    logic             req;
    logic             tag_match;
    line_t            merged;

    assign req_addr.raw = mem_addr_i;
    assign idx          = req_addr.raw[OFFSET_BITS +: IDX_W];
    assign tag          = req_addr.raw[31 -: TAG_W];

    assign req       = mem_read_i | mem_write_i;
    assign tag_match = valid_q[idx] && (tag_arr[idx] == tag);

    // victim line goes back to where it came from
    always_comb begin
        fill_addr.raw = {tag, idx, {OFFSET_BITS{1'b0}}};
        wb_addr.raw   = {tag_arr[idx], idx, {OFFSET_BITS{1'b0}}};
    end

    // byte merge for write hits
    always_comb begin
        merged = data_arr[idx];
        for (int b = 0; b < $bits(line_mask_t); b++) begin
            if (mem_mask_i[b]) begin
                merged[8*b +: 8] = mem_wdata_i[8*b +: 8];
            end
        end
    end

    always_comb begin
        state_d      = state_q;
        mem_resp_o   = 1'b0;
        hit_o        = 1'b0;
        miss_o       = 1'b0;
        pmem_read_o  = 1'b0;
        pmem_write_o = 1'b0;
        case (state_q)
            S_IDLE: begin
                if (req) begin
                    state_d = S_LOOKUP;
                end
            end
            S_LOOKUP: begin
                if (tag_match) begin
                    mem_resp_o = 1'b1;
                    hit_o      = !filled_q;  // no hit pulse for the refilled line
                    state_d    = S_IDLE;
                end else begin
                    miss_o  = 1'b1;
                    state_d = (valid_q[idx] && dirty_q[idx]) ? S_WBACK : S_FILL;
                end
            end
            S_WBACK: begin
                pmem_write_o = 1'b1;
                if (pmem_resp_i) begin
                    state_d = S_FILL;
                end
            end
            S_FILL: begin
                pmem_read_o = 1'b1;
                if (pmem_resp_i) begin
                    state_d = S_LOOKUP;   // retry now hits
                end
            end
            default: state_d = S_IDLE;
        endcase
    end

    assign pmem_addr_o  = (state_q == S_WBACK) ? wb_addr.raw : fill_addr.raw;
    assign pmem_wdata_o = data_arr[idx];
    assign mem_rdata_o  = data_arr[idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q  <= S_IDLE;
            valid_q  <= '0;
            dirty_q  <= '0;
            filled_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == S_FILL && pmem_resp_i) begin
                valid_q[idx] <= 1'b1;
                dirty_q[idx] <= 1'b0;
                filled_q     <= 1'b1;
            end else if (state_q == S_LOOKUP && tag_match) begin
                filled_q <= 1'b0;
                if (mem_write_i) begin
                    dirty_q[idx] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == S_FILL && pmem_resp_i) begin
            data_arr[idx] <= pmem_rdata_i;
            tag_arr[idx]  <= tag;
        end else if (state_q == S_LOOKUP && tag_match && mem_write_i) begin
            data_arr[idx] <= merged;
        end
    end

    // core side never asks for both at once
    a_rw_excl: assert property (@(posedge clk) disable iff (rst)
        !(mem_read_i && mem_write_i));

    a_hit_miss_excl: assert property (@(posedge clk) disable iff (rst)
        !(hit_o && miss_o));

endmodule

/* hdl/cache_arbiter.sv */
`timescale 1ns/1ps

module cache_arbiter (
    input  logic                 clk,
    input  logic                 rst,
    input  mem_types_pkg::word_t icache_addr_i,
    input  logic                 icache_read_i,
    output mem_types_pkg::line_t icache_rdata_o,
    output logic                 icache_resp_o,
    input  mem_types_pkg::word_t dcache_addr_i,
    input  logic                 dcache_read_i,
    input  logic                 dcache_write_i,
    input  mem_types_pkg::line_t dcache_wdata_i,
    output mem_types_pkg::line_t dcache_rdata_o,
    output logic                 dcache_resp_o,
    output mem_types_pkg::word_t mem_addr_o,
    output logic                 mem_read_o,
    output logic                 mem_write_o,
    output mem_types_pkg::line_t mem_wdata_o,
    input  mem_types_pkg::line_t mem_rdata_i,
    input  logic                 mem_resp_i
);
    typedef enum logic [1:0] {
        G_IDLE,
        G_ICACHE,
        G_DCACHE
    } grant_e;

    grant_e grant_q;

    // data side first, grant held until the adaptor answers
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            grant_q <= G_IDLE;
        end else begin
            case (grant_q)
                G_IDLE: begin
                    if (dcache_read_i || dcache_write_i) begin
                        grant_q <= G_DCACHE;
                    end else if (icache_read_i) begin
                        grant_q <= G_ICACHE;
                    end
                end
                default: begin
                    if (mem_resp_i) begin
                        grant_q <= G_IDLE;
                    end
                end
            endcase
        end
    end

    always_comb begin
        mem_addr_o  = dcache_addr_i;
        mem_read_o  = 1'b0;
        mem_write_o = 1'b0;
        case (grant_q)
            G_ICACHE: begin
                mem_addr_o = icache_addr_i;
                mem_read_o = icache_read_i;
            end
            G_DCACHE: begin
                mem_read_o  = dcache_read_i;
                mem_write_o = dcache_write_i;
            end
            default: ;
        endcase
    end

    assign mem_wdata_o    = dcache_wdata_i;   // only the data cache writes
    assign icache_rdata_o = mem_rdata_i;
    assign dcache_rdata_o = mem_rdata_i;
    assign icache_resp_o  = (grant_q == G_ICACHE) && mem_resp_i;
    assign dcache_resp_o  = (grant_q == G_DCACHE) && mem_resp_i;

    a_one_owner: assert property (@(posedge clk) disable iff (rst)
        !(icache_resp_o && dcache_resp_o));

endmodule

/* hdl/cacheline_adaptor.sv */
`timescale 1ns/1ps

module cacheline_adaptor (
    input  logic                 clk,
    input  logic                 rst,
    input  mem_types_pkg::line_t line_i,
    output mem_types_pkg::line_t line_o,
    input  mem_types_pkg::word_t addr_i,
    input  logic                 read_i,
    input  logic                 write_i,
    output logic                 resp_o,
    input  mem_types_pkg::beat_t burst_i,
    output mem_types_pkg::beat_t burst_o,
    output mem_types_pkg::word_t addr_o,
    output logic                 read_o,
    output logic                 write_o,
    input  logic                 resp_i
);
    import mem_types_pkg::*;

    localparam int CNT_W  = $clog2(BEATS_PER_LINE);
    localparam int LINE_W = $bits(line_t);
    localparam int BEAT_W = $bits(beat_t);

    typedef enum logic [1:0] {
        A_IDLE,
        A_READ,
        A_WRITE,
        A_DONE
    } adapt_e;

    adapt_e           state_q;
    logic [CNT_W-1:0] beat_q;
    line_t            shift_q;
    word_t            addr_q;
    logic             busy;
    logic             last_beat;

    assign busy      = (state_q == A_READ) || (state_q == A_WRITE);
    assign last_beat = resp_i && (beat_q == CNT_W'(BEATS_PER_LINE - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= A_IDLE;
            beat_q  <= '0;
        end else begin
            case (state_q)
                A_IDLE: begin
                    beat_q <= '0;
                    if (read_i) begin
                        state_q <= A_READ;
                    end else if (write_i) begin
                        state_q <= A_WRITE;
                    end
                end
                A_READ, A_WRITE: begin
                    if (resp_i) begin
                        beat_q <= beat_q + 1'b1;
                    end
                    if (last_beat) begin
                        state_q <= A_DONE;
                    end
                end
                default: state_q <= A_IDLE;   // one resp cycle
            endcase
        end
    end

    // one shifter serves both ways, beat 0 at the bottom
    always_ff @(posedge clk) begin
        if (state_q == A_IDLE) begin
            addr_q  <= addr_i;
            shift_q <= line_i;
        end else if (busy && resp_i) begin
            shift_q <= {burst_i, shift_q[LINE_W-1:BEAT_W]};
        end
    end

    assign read_o  = (state_q == A_READ);
    assign write_o = (state_q == A_WRITE);
    assign resp_o  = (state_q == A_DONE);
    assign addr_o  = addr_q;
    assign burst_o = shift_q[BEAT_W-1:0];   // next beat shows after each accept
    assign line_o  = shift_q;

    a_resp_pulse: assert property (@(posedge clk) disable iff (rst)
        resp_o |=> !resp_o);

endmodule

/* hdl/mem_subsys.sv */
`timescale 1ns/1ps

module mem_subsys #(
    parameter int SETS = mem_types_pkg::MEM_SETS
) (
    input  logic                 clk,
    input  logic                 rst,
    input  mem_types_pkg::word_t ifetch_addr_i,
    input  logic                 ifetch_read_i,
    output mem_types_pkg::word_t ifetch_rdata_o,
    output logic                 ifetch_resp_o,
    input  mem_types_pkg::word_t data_addr_i,
    input  logic                 data_read_i,
    input  logic                 data_write_i,
    input  logic [3:0]           data_wmask_i,
    input  mem_types_pkg::word_t data_wdata_i,
    output mem_types_pkg::word_t data_rdata_o,
    output logic                 data_resp_o,
    output mem_types_pkg::word_t bmem_addr_o,
    output logic                 bmem_read_o,
    output logic                 bmem_write_o,
    output mem_types_pkg::beat_t bmem_wdata_o,
    input  mem_types_pkg::beat_t bmem_rdata_i,
    input  logic                 bmem_resp_i,
    output logic                 ihit_o,
    output logic                 imiss_o,
    output logic                 dhit_o,
    output logic                 dmiss_o
);
    import mem_types_pkg::*;

    // core word ports <-> line-wide caches
    word_t      i_line_addr, d_line_addr;
    line_t      i_line_rdata, d_line_rdata;
    line_t      i_line_wdata, d_line_wdata;
    line_mask_t i_line_mask, d_line_mask;

    // caches <-> arbiter
    word_t ic_pmem_addr, dc_pmem_addr;
    logic  ic_pmem_read, dc_pmem_read, dc_pmem_write;
    line_t ic_pmem_rdata, dc_pmem_rdata, dc_pmem_wdata;
    logic  ic_pmem_resp, dc_pmem_resp;

    // arbiter <-> adaptor
    word_t arb_addr;
    logic  arb_read, arb_write, arb_resp;
    line_t arb_wdata, arb_rdata;

    word_adapter u_iword (
        .addr_i(ifetch_addr_i), .wdata_i('0), .wmask_i(4'h0),   // fetch never writes
        .line_rdata_i(i_line_rdata), .line_addr_o(i_line_addr),
        .line_wdata_o(i_line_wdata), .line_mask_o(i_line_mask), .rdata_o(ifetch_rdata_o)
    );

    word_adapter u_dword (
        .addr_i(data_addr_i), .wdata_i(data_wdata_i), .wmask_i(data_wmask_i),
        .line_rdata_i(d_line_rdata), .line_addr_o(d_line_addr),
        .line_wdata_o(d_line_wdata), .line_mask_o(d_line_mask), .rdata_o(data_rdata_o)
    );

    cache #(.SETS(SETS)) u_icache (
        .clk(clk), .rst(rst),
        .mem_addr_i(i_line_addr), .mem_read_i(ifetch_read_i), .mem_write_i(1'b0),
        .mem_mask_i(i_line_mask), .mem_wdata_i(i_line_wdata),
        .mem_rdata_o(i_line_rdata), .mem_resp_o(ifetch_resp_o),
        .pmem_addr_o(ic_pmem_addr), .pmem_read_o(ic_pmem_read),
        .pmem_write_o(), .pmem_wdata_o(),   // never dirty
        .pmem_rdata_i(ic_pmem_rdata), .pmem_resp_i(ic_pmem_resp),
        .hit_o(ihit_o), .miss_o(imiss_o)
    );

    cache #(.SETS(SETS)) u_dcache (
        .clk(clk), .rst(rst),
        .mem_addr_i(d_line_addr), .mem_read_i(data_read_i), .mem_write_i(data_write_i),
        .mem_mask_i(d_line_mask), .mem_wdata_i(d_line_wdata),
        .mem_rdata_o(d_line_rdata), .mem_resp_o(data_resp_o),
        .pmem_addr_o(dc_pmem_addr), .pmem_read_o(dc_pmem_read),
        .pmem_write_o(dc_pmem_write), .pmem_wdata_o(dc_pmem_wdata),
        .pmem_rdata_i(dc_pmem_rdata), .pmem_resp_i(dc_pmem_resp),
        .hit_o(dhit_o), .miss_o(dmiss_o)
    );

    cache_arbiter u_arbiter (
        .clk(clk), .rst(rst),
        .icache_addr_i(ic_pmem_addr), .icache_read_i(ic_pmem_read),
        .icache_rdata_o(ic_pmem_rdata), .icache_resp_o(ic_pmem_resp),
        .dcache_addr_i(dc_pmem_addr), .dcache_read_i(dc_pmem_read),
        .dcache_write_i(dc_pmem_write), .dcache_wdata_i(dc_pmem_wdata),
        .dcache_rdata_o(dc_pmem_rdata), .dcache_resp_o(dc_pmem_resp),
        .mem_addr_o(arb_addr), .mem_read_o(arb_read), .mem_write_o(arb_write),
        .mem_wdata_o(arb_wdata), .mem_rdata_i(arb_rdata), .mem_resp_i(arb_resp)
    );

    cacheline_adaptor u_adaptor (
        .clk(clk), .rst(rst),
        .line_i(arb_wdata), .line_o(arb_rdata), .addr_i(arb_addr),
        .read_i(arb_read), .write_i(arb_write), .resp_o(arb_resp),
        .burst_i(bmem_rdata_i), .burst_o(bmem_wdata_o), .addr_o(bmem_addr_o),
        .read_o(bmem_read_o), .write_o(bmem_write_o), .resp_i(bmem_resp_i)
    );

endmodule

/* hdl/mem_types_pkg.sv */
package mem_types_pkg;

    localparam int WORDS_PER_LINE = 8;
    localparam int BEATS_PER_LINE = 4;
    localparam int OFFSET_BITS    = 5;   // byte offset within a 32-byte line

    // default set count, the top level passes it down as SETS
    localparam int MEM_SETS   = 8;
    localparam int INDEX_BITS = $clog2(MEM_SETS);
    localparam int TAG_BITS   = 32 - INDEX_BITS - OFFSET_BITS;

    typedef logic [31:0]                    word_t;
    typedef logic [WORDS_PER_LINE*32-1:0]   line_t;
    typedef logic [63:0]                    beat_t;
    typedef logic [WORDS_PER_LINE*4-1:0]    line_mask_t;

    typedef struct packed {
        logic [TAG_BITS-1:0]    tag;
        logic [INDEX_BITS-1:0]  index;
        logic [OFFSET_BITS-1:0] offset;
    } addr_fields_t;

    // same address word, seen raw or split for the cache
    typedef union packed {
        word_t        raw;
        addr_fields_t fields;
    } mem_addr_u;

endpackage

/* hdl/word_adapter.sv */
`timescale 1ns/1ps

module word_adapter (
    input  mem_types_pkg::word_t      addr_i,
    input  mem_types_pkg::word_t      wdata_i,
    input  logic [3:0]                wmask_i,
    input  mem_types_pkg::line_t      line_rdata_i,
    output mem_types_pkg::word_t      line_addr_o,
    output mem_types_pkg::line_t      line_wdata_o,
    output mem_types_pkg::line_mask_t line_mask_o,
    output mem_types_pkg::word_t      rdata_o
);
    import mem_types_pkg::*;

    localparam int SEL_W = $clog2(WORDS_PER_LINE);

    mem_addr_u        addr;
    mem_addr_u        line_addr;
    logic [SEL_W-1:0] word_sel;

    assign addr.raw = addr_i;
    assign word_sel = addr.fields.offset[OFFSET_BITS-1 -: SEL_W];  // drop the byte bits

    // cache only ever sees line-aligned addresses
    always_comb begin
        line_addr               = addr;
        line_addr.fields.offset = '0;
    end

    assign line_addr_o = line_addr.raw;

    // word goes to every slot, the mask picks the real one
    assign line_wdata_o = {WORDS_PER_LINE{wdata_i}};
    assign line_mask_o  = line_mask_t'(wmask_i) << (4 * word_sel);

    assign rdata_o = line_rdata_i[$bits(word_t)*word_sel +: $bits(word_t)];

endmodule

/* mem_subsys.f */
hdl/mem_types_pkg.sv
hdl/word_adapter.sv
hdl/cache.sv
hdl/cache_arbiter.sv
hdl/cacheline_adaptor.sv
hdl/mem_subsys.sv
tests/burst_mem_model.sv
tests/tb_mem_subsys.sv

/* run_sim.sh */
#!/bin/sh
# build and run the memory subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_mem_subsys \
    -f mem_subsys.f \
    -o sim_tb

./obj_dir/sim_tb

/* tests/burst_mem_model.sv */
`timescale 1ns/1ps

module burst_mem_model #(
    parameter int LATENCY = 3
) (
    input  logic                 clk,
    input  logic                 rst,
    input  mem_types_pkg::word_t addr_i,
    input  logic                 read_i,
    input  logic                 write_i,
    input  mem_types_pkg::beat_t wdata_i,
    output mem_types_pkg::beat_t rdata_o,
    output logic                 resp_o
);
    import mem_types_pkg::*;

    word_t      mem [1024];   // 4 KB window
    logic       busy_q;
    logic       wr_q;
    int         cnt_q;
    word_t      addr_q;
    logic [1:0] beat;
    logic [9:0] widx;

    initial begin
        for (int i = 0; i < 1024; i++) begin
            mem[i] = (32'(i) << 2) ^ 32'h5a5a0000;
        end
    end

    assign resp_o  = busy_q && (cnt_q >= LATENCY) && (cnt_q < LATENCY + 4);
    assign beat    = 2'(cnt_q - LATENCY);
    assign widx    = {addr_q[11:5], beat, 1'b0};   // two words per beat
    assign rdata_o = {mem[widx + 10'd1], mem[widx]};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy_q <= 1'b0;
            wr_q   <= 1'b0;
            cnt_q  <= 0;
            addr_q <= '0;
        end else if (!busy_q) begin
            if (read_i || write_i) begin
                busy_q <= 1'b1;
                wr_q   <= write_i;
                cnt_q  <= 0;
                addr_q <= addr_i;
            end
        end else begin
            cnt_q <= cnt_q + 1;
            if (cnt_q == LATENCY + 3) begin
                busy_q <= 1'b0;   // last beat
            end
        end
    end

    always @(posedge clk) begin
        if (resp_o && wr_q) begin
            mem[widx]         <= wdata_i[31:0];
            mem[widx + 10'd1] <= wdata_i[63:32];
        end
    end

endmodule

/* tests/tb_mem_subsys.sv */
`timescale 1ns/1ps

module tb_mem_subsys;
    import mem_types_pkg::*;

    // fetch pairs, store/load pairs, evict triples, fetch+load pairs, mixed stream of up to two
    localparam int N_REQ   = 4 * 2 + 12 * 2 + 4 * 3 + 6 * 2 + 200 * 2;
    localparam int TIMEOUT = N_REQ * 40;

    logic       clk = 1'b0;
    logic       rst;
    word_t      ifetch_addr, ifetch_rdata, data_addr, data_wdata, data_rdata, bmem_addr;
    logic       ifetch_read, ifetch_resp, data_read, data_write, data_resp;
    logic [3:0] data_wmask;
    logic       bmem_read, bmem_write, bmem_resp;
    beat_t      bmem_wdata, bmem_rdata;
    logic       ihit, imiss, dhit, dmiss;

    integer seed   = 45;
    int     cycles = 0;

    // shadow of bytes written by stores, per word of the 4 KB window
    word_t      shadow_data [1024];
    logic [3:0] shadow_mask [1024];
    // direct-mapped tag models
    logic [23:0] itag [8];
    logic [23:0] dtag [8];
    logic [7:0]  ivalid, dvalid;

    word_t exp_irdata, exp_drdata;
    logic  exp_ihit, exp_dhit, exp_dread;
    logic  seen_ihit, seen_imiss, seen_dhit, seen_dmiss;
    time   i_done_t, d_done_t;

    always #50 clk = ~clk;

    mem_subsys #(.SETS(8)) dut0 (
        .clk(clk), .rst(rst),
        .ifetch_addr_i(ifetch_addr), .ifetch_read_i(ifetch_read),
        .ifetch_rdata_o(ifetch_rdata), .ifetch_resp_o(ifetch_resp),
        .data_addr_i(data_addr), .data_read_i(data_read), .data_write_i(data_write),
        .data_wmask_i(data_wmask), .data_wdata_i(data_wdata),
        .data_rdata_o(data_rdata), .data_resp_o(data_resp),
        .bmem_addr_o(bmem_addr), .bmem_read_o(bmem_read), .bmem_write_o(bmem_write),
        .bmem_wdata_o(bmem_wdata), .bmem_rdata_i(bmem_rdata), .bmem_resp_i(bmem_resp),
        .ihit_o(ihit), .imiss_o(imiss), .dhit_o(dhit), .dmiss_o(dmiss)
    );

    burst_mem_model #(.LATENCY(3)) u_mem (
        .clk(clk), .rst(rst), .addr_i(bmem_addr), .read_i(bmem_read),
        .write_i(bmem_write), .wdata_i(bmem_wdata), .rdata_o(bmem_rdata), .resp_o(bmem_resp)
    );

    // pattern overlaid with every byte a store has touched
    function automatic word_t ref_word(input word_t a);
        word_t w;
        int    i;
        w = {a[31:2], 2'b00} ^ 32'h5a5a0000;
        i = int'(a[11:2]);
        for (int b = 0; b < 4; b++) begin
            if (shadow_mask[i][b]) begin
                w[8*b +: 8] = shadow_data[i][8*b +: 8];
            end
        end
        return w;
    endfunction

    function automatic word_t rand_iaddr();
        word_t r;
        r = $random(seed);
        return {20'h0, 1'b0, r[10:2], 2'b00};   // fetch half of the window
    endfunction

    function automatic word_t rand_daddr();
        word_t r;
        r = $random(seed);
        return {20'h0, 1'b1, r[10:2], 2'b00};
    endfunction

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("Error %s expected %h actual %h", name, exp, act);
            $display("sim failed");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("Error %s expected %h actual %h", name, exp, act);
            $display("sim failed");
            $fatal(1, "flag mismatch");
        end
    endtask

    task automatic issue_fetch(input word_t a);
        @(posedge clk);
        exp_irdata   = ref_word(a);
        exp_ihit     = ivalid[a[7:5]] && itag[a[7:5]] == a[31:8];
        ivalid[a[7:5]] = 1'b1;
        itag[a[7:5]]   = a[31:8];
        ifetch_addr <= a;
        ifetch_read <= 1'b1;
        do @(posedge clk); while (!ifetch_resp);
        i_done_t = $time;
        ifetch_read <= 1'b0;
    endtask

    task automatic issue_data(input word_t a, input logic wr, input word_t wd,
                              input logic [3:0] m);
        int i;
        @(posedge clk);
        i          = int'(a[11:2]);
        exp_dhit   = dvalid[a[7:5]] && dtag[a[7:5]] == a[31:8];
        exp_dread  = !wr;
        exp_drdata = ref_word(a);
        dvalid[a[7:5]] = 1'b1;
        dtag[a[7:5]]   = a[31:8];
        if (wr) begin
            for (int b = 0; b < 4; b++) begin
                if (m[b]) begin
                    shadow_data[i][8*b +: 8] = wd[8*b +: 8];
                    shadow_mask[i][b]        = 1'b1;
                end
            end
        end
        data_addr  <= a;
        data_read  <= !wr;
        data_write <= wr;
        data_wdata <= wd;
        data_wmask <= m;
        do @(posedge clk); while (!data_resp);
        d_done_t = $time;
        data_read  <= 1'b0;
        data_write <= 1'b0;
    endtask

    // fetch and load in the same cycle
    task automatic issue_pair(input word_t ia, input word_t da);
        logic both_miss;
        both_miss = !(ivalid[ia[7:5]] && itag[ia[7:5]] == ia[31:8])
                 && !(dvalid[da[7:5]] && dtag[da[7:5]] == da[31:8]);
        fork
            issue_fetch(ia);
            issue_data(da, 1'b0, '0, 4'h0);
        join
        if (both_miss && d_done_t > i_done_t) begin
            $display("data response came later than the instruction response");
            $display("sim failed");
            $fatal(1, "arbiter priority");
        end
    endtask

    // compares every response with the expectation set at issue
    always @(posedge clk) begin
        if (!rst) begin
            if (ifetch_resp) begin
                check_word("ifetch_rdata_o", exp_irdata, ifetch_rdata);
                check_flag("ihit_o", exp_ihit, seen_ihit | ihit);
                check_flag("imiss_o", !exp_ihit, seen_imiss | imiss);
                seen_ihit  = 1'b0;
                seen_imiss = 1'b0;
            end else begin
                seen_ihit  = seen_ihit | ihit;
                seen_imiss = seen_imiss | imiss;
            end
            if (data_resp) begin
                if (exp_dread) check_word("data_rdata_o", exp_drdata, data_rdata);
                check_flag("dhit_o", exp_dhit, seen_dhit | dhit);
                check_flag("dmiss_o", !exp_dhit, seen_dmiss | dmiss);
                seen_dhit  = 1'b0;
                seen_dmiss = 1'b0;
            end else begin
                seen_dhit  = seen_dhit | dhit;
                seen_dmiss = seen_dmiss | dmiss;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("timeout after %0d cycles waiting for a response", cycles);
            $display("sim failed");
            $fatal(1, "timeout");
        end
    end

    initial begin
        word_t a;
        word_t r;
        rst = 1'b1;
        ifetch_addr = '0;
        ifetch_read = 1'b0;
        data_addr   = '0;
        data_read   = 1'b0;
        data_write  = 1'b0;
        data_wmask  = 4'h0;
        data_wdata  = '0;
        ivalid = '0;
        dvalid = '0;
        seen_ihit = 1'b0;
        seen_imiss = 1'b0;
        seen_dhit = 1'b0;
        seen_dmiss = 1'b0;
        exp_dread = 1'b0;
        for (int i = 0; i < 1024; i++) begin
            shadow_data[i] = '0;
            shadow_mask[i] = 4'h0;
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // quiet ports until the first request
        repeat (3) begin
            @(posedge clk);
            check_flag("ifetch_resp_o", 1'b0, ifetch_resp);
            check_flag("data_resp_o", 1'b0, data_resp);
            check_flag("bmem_read_o", 1'b0, bmem_read);
            check_flag("bmem_write_o", 1'b0, bmem_write);
            check_flag("ihit_o", 1'b0, ihit);
            check_flag("imiss_o", 1'b0, imiss);
            check_flag("dhit_o", 1'b0, dhit);
            check_flag("dmiss_o", 1'b0, dmiss);
        end

        for (int k = 0; k < 4; k++) begin   // miss then hit in one line
            a = rand_iaddr();
            issue_fetch(a);
            issue_fetch(a ^ 32'h4);
        end
        for (int k = 0; k < 12; k++) begin
            a = rand_daddr();
            r = $random(seed);
            issue_data(a, 1'b1, $random(seed), r[3:0]);
            issue_data(a, 1'b0, '0, 4'h0);
        end
        for (int k = 0; k < 4; k++) begin   // evict dirty line and refill
            a = rand_daddr();
            issue_data(a, 1'b1, $random(seed), 4'hf);
            issue_data(a ^ 32'h100, 1'b0, '0, 4'h0);
            issue_data(a, 1'b0, '0, 4'h0);
        end
        for (int k = 0; k < 6; k++) begin
            issue_pair(rand_iaddr(), rand_daddr());
        end
        for (int k = 0; k < 200; k++) begin
            r = $random(seed);
            case (r[1:0])
                2'd0: issue_fetch(rand_iaddr());
                2'd1: issue_data(rand_daddr(), 1'b0, '0, 4'h0);
                2'd2: issue_data(rand_daddr(), 1'b1, $random(seed), r[7:4]);
                default: issue_pair(rand_iaddr(), rand_daddr());
            endcase
        end

        repeat (2) @(posedge clk);
        $display("sim passed");
        $finish;
    end

endmodule
